// File: logic/icache_pkg.sv
package icache_pkg;

  // --------------------
  // cache geometry
  // --------------------
  localparam int XLEN       = 32;                   // fetch word width
  localparam int LINE_WORDS = 4;                    // words per line, 16 bytes
  localparam int SETS       = 64;

  localparam int WORD_BITS  = $clog2(LINE_WORDS);           // word select in a line
  localparam int OFF_BITS   = $clog2(LINE_WORDS * XLEN / 8); // byte offset in a line
  localparam int IDX_BITS   = $clog2(SETS);
  localparam int TAG_BITS   = XLEN - IDX_BITS - OFF_BITS;
  localparam int LANE_BITS  = OFF_BITS - WORD_BITS;         // byte lanes in a word

  // --------------------
  // address split
  // --------------------
  typedef struct packed
  {
    logic [TAG_BITS-1:0]  tag;
    logic [IDX_BITS-1:0]  idx;
    logic [WORD_BITS-1:0] word;  // critical word on a miss
    logic [LANE_BITS-1:0] lane;  // ignored, fetches are whole words
  } fetch_adr_t;

  // --------------------
  // transfer records
  // --------------------

  // one beat from the bus, already placed by word index
  typedef struct packed
  {
    logic                 valid;
    logic [WORD_BITS-1:0] word;
    logic [XLEN-1:0]      data;
  } fill_word_t;

  // miss request towards the bus side
  typedef struct packed
  {
    logic       start;  // single cycle
    fetch_adr_t adr;    // line address, word bits kept
  } fill_cmd_t;

  // a complete line, word 0 in the low bits
  typedef logic [LINE_WORDS-1:0][XLEN-1:0] line_t;

endpackage

// File: logic/icache_lookup.sv
`timescale 1ns/1ps

module icache_lookup #(
  parameter int WAYS = 2
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        req_i,
  input  icache_pkg::fetch_adr_t      adr_i,
  input  logic                        flush_i,
  output icache_pkg::fill_cmd_t       fill_cmd_o,
  input  logic                        fill_done_i,
  input  logic                        fill_err_i,
  input  icache_pkg::line_t           line_i,
  input  logic                        line_full_i,
  output logic                        ack_o,
  output logic                        err_o,
  output logic [icache_pkg::XLEN-1:0] q_o
);
  import icache_pkg::*;

  localparam int WSEL = (WAYS > 1) ? $clog2(WAYS) : 1;  // way number width

  typedef enum logic [1:0] {ARMED, FLUSH, WAIT_FILL, RECOVER} mem_state_e;

  mem_state_e             state_q;
  logic                   pend_q;        // request not yet answered
  logic                   look_q;        // tag/data read for a request last cycle
  logic                   flush_hold_q;  // flush seen while busy
  logic                   fill_busy_q;   // burst running on the bus side
  fetch_adr_t             adr_q;
  logic [IDX_BITS-1:0]    rd_idx;
  logic                   flush_req;
  logic                   start;
  logic                   wr_line;
  logic [WAYS-1:0]        way_hit;
  logic [WAYS-1:0]        way_we;
  line_t [WAYS-1:0]       way_q;
  line_t                  hit_line;
  logic                   cache_hit;
  logic [19:0]            way_rnd_q;
  logic [WSEL-1:0]        fill_way_q;

  // --------------------
  // request tracking
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      pend_q <= 1'b0;
      look_q <= 1'b0;
    end
    else
    begin
      pend_q <= req_i | (pend_q & ~ack_o & ~err_o);
      look_q <= req_i | (state_q == RECOVER && pend_q);  // replay after fill or flush
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (req_i)
      adr_q <= adr_i;
  end

  // held request re-reads the arrays in recover
  assign rd_idx = (state_q == RECOVER && pend_q) ? adr_q.idx : adr_i.idx;

  // --------------------
  // ways
  // --------------------
  for (genvar w = 0; w < WAYS; w++)
  begin : g_way
    logic [TAG_BITS-1:0] tag_mem [SETS];
    line_t               data_mem [SETS];
    logic [SETS-1:0]     valid_q;
    logic [TAG_BITS-1:0] tag_rd;
    line_t               data_rd;
    logic                valid_rd_q;

    assign way_we[w] = wr_line & (fill_way_q == WSEL'(w));

    always_ff @(posedge clk_i)
    begin
      if (way_we[w])
      begin
        tag_mem[adr_q.idx]  <= adr_q.tag;
        data_mem[adr_q.idx] <= line_i;
      end
      tag_rd  <= tag_mem[rd_idx];   // read first, no bypass
      data_rd <= data_mem[rd_idx];
    end

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
      if (!rst_ni)
      begin
        valid_q    <= '0;
        valid_rd_q <= 1'b0;
      end
      else
      begin
        if (flush_i)
          valid_q <= '0;               // whole cache in one edge
        else if (way_we[w])
          valid_q[adr_q.idx] <= 1'b1;
        valid_rd_q <= valid_q[rd_idx];
      end
    end

    assign way_hit[w] = valid_rd_q & (tag_rd == adr_q.tag);
    assign way_q[w]   = data_rd & {$bits(line_t){way_hit[w]}};  // and-or mux leg
  end

  always_comb
  begin
    hit_line = '0;
    for (int w = 0; w < WAYS; w++)
      hit_line = hit_line | way_q[w];
  end

  assign cache_hit = |way_hit;
  assign q_o       = hit_line[adr_q.word];

  // --------------------
  // miss controller
  // --------------------
  assign flush_req = flush_i | flush_hold_q;
  assign start     = (state_q == ARMED) & look_q & ~cache_hit & ~flush_req;
  assign wr_line   = (state_q == WAIT_FILL) & ~fill_busy_q & line_full_i;

  assign ack_o = (state_q == ARMED) & look_q & cache_hit;
  assign err_o = (state_q == WAIT_FILL) & fill_err_i;  // bus error ends the request

  assign fill_cmd_o.start = start;
  assign fill_cmd_o.adr   = adr_q;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q      <= ARMED;
      flush_hold_q <= 1'b0;
      fill_busy_q  <= 1'b0;
    end
    else
    begin
      flush_hold_q <= (state_q == WAIT_FILL || state_q == RECOVER) & flush_req;
      fill_busy_q  <= start | (fill_busy_q & ~fill_done_i & ~fill_err_i);
      unique case (state_q)
        ARMED:
          if (flush_req)
            state_q <= FLUSH;
          else if (start)
            state_q <= WAIT_FILL;
        FLUSH:
          if (!flush_i)
            state_q <= RECOVER;  // re-read for a request that came with the flush
        WAIT_FILL:
          if (err_o || wr_line)
            state_q <= RECOVER;
        default:
          state_q <= ARMED;
      endcase
    end
  end

  // random replacement, frozen while a fill runs
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      way_rnd_q <= '0;
    else if (state_q != WAIT_FILL)
      way_rnd_q <= {way_rnd_q[18:0], way_rnd_q[19] ~^ way_rnd_q[16]};
  end

  always_ff @(posedge clk_i)
  begin
    if (start)
      fill_way_q <= (WAYS > 1) ? way_rnd_q[WSEL-1:0] : '0;
  end

  a_one_way_hits: assert property (@(posedge clk_i) disable iff (!rst_ni)
    look_q |-> $onehot0(way_hit));

  a_no_restart: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fill_cmd_o.start |-> !fill_busy_q);

endmodule

// File: logic/icache_line_buf.sv
`timescale 1ns/1ps

module icache_line_buf (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  icache_pkg::fill_cmd_t  fill_cmd_i,
  input  icache_pkg::fill_word_t fill_word_i,
  output icache_pkg::line_t      line_o,
  output logic                   line_full_o
);
  import icache_pkg::*;

  line_t                 line_q;
  logic [LINE_WORDS-1:0] mask_q;  // one bit per word slot

  // --------------------
  // word slots
  // --------------------
  always_ff @(posedge clk_i)
  begin
    if (fill_word_i.valid)
      line_q[fill_word_i.word] <= fill_word_i.data;  // wrap order sorted out here
  end

  // --------------------
  // fill mask
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      mask_q <= '0;
    end
    else
    begin
      if (fill_cmd_i.start)
        mask_q <= '0;                         // new miss
      else if (fill_word_i.valid)
        mask_q[fill_word_i.word] <= 1'b1;
    end
  end

  // high from the cycle after the last beat until the next start
  assign line_full_o = &mask_q;
  assign line_o      = line_q;

  // bus must hand out each word of the line once
  a_no_rewrite: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fill_word_i.valid |-> !mask_q[fill_word_i.word]);

endmodule

// File: logic/icache_fill_ctrl.sv
`timescale 1ns/1ps

module icache_fill_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  icache_pkg::fill_cmd_t       fill_cmd_i,
  output logic                        bus_stb_o,
  output logic [31:0]                 bus_adr_o,
  input  logic                        bus_stb_ack_i,
  input  logic                        bus_ack_i,
  input  logic                        bus_err_i,
  input  logic [31:0]                 bus_adr_i,
  input  logic [icache_pkg::XLEN-1:0] bus_q_i,
  output icache_pkg::fill_word_t      fill_word_o,
  output logic                        fill_done_o,
  output logic                        fill_err_o
);
  import icache_pkg::*;

  typedef enum logic [1:0] {IDLE, WAIT_BUS, BURST} bus_state_e;

  bus_state_e           state_q;
  fetch_adr_t           adr_q;       // burst start address
  logic [WORD_BITS-1:0] beat_cnt_q;  // beats left minus one
  fetch_adr_t           beat_adr;
  logic                 beat;
  logic                 last_beat;

  assign beat_adr  = fetch_adr_t'(bus_adr_i);
  assign beat      = (state_q == BURST) & bus_ack_i & ~bus_err_i;
  assign last_beat = beat & (beat_cnt_q == '0);

  // --------------------
  // bus FSM
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q    <= IDLE;
      beat_cnt_q <= '0;
    end
    else
    begin
      unique case (state_q)
        IDLE:
          if (fill_cmd_i.start)
            state_q <= WAIT_BUS;         // strobe goes out next cycle
        WAIT_BUS:
          if (bus_err_i)
            state_q <= IDLE;
          else if (bus_stb_ack_i)
          begin
            state_q    <= BURST;
            beat_cnt_q <= WORD_BITS'(LINE_WORDS - 1);
          end
        BURST:
          if (bus_err_i || last_beat)
            state_q <= IDLE;             // error cuts the burst short
          else if (beat)
            beat_cnt_q <= beat_cnt_q - 1'b1;
        default:
          state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (state_q == IDLE && fill_cmd_i.start)
    begin
      adr_q      <= fill_cmd_i.adr;
      adr_q.lane <= '0;                  // word aligned, critical word kept
    end
  end

  // --------------------
  // outputs
  // --------------------
  assign bus_stb_o = (state_q == WAIT_BUS);
  assign bus_adr_o = adr_q;

  assign fill_word_o.valid = beat;
  assign fill_word_o.word  = beat_adr.word;  // slot from the returned address
  assign fill_word_o.data  = bus_q_i;

  assign fill_done_o = last_beat;
  assign fill_err_o  = bus_err_i & (state_q != IDLE);

  // request held steady under back-pressure
  a_adr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_stb_o && !bus_stb_ack_i |=> bus_stb_o && $stable(bus_adr_o));

endmodule

// File: logic/icache_top.sv
`timescale 1ns/1ps

module icache_top #(
  parameter int WAYS = 2
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // core side
  input  logic                        req_i,
  input  icache_pkg::fetch_adr_t      adr_i,
  input  logic                        flush_i,
  output logic                        ack_o,
  output logic                        err_o,
  output logic [icache_pkg::XLEN-1:0] q_o,
  // bus side
  output logic                        bus_stb_o,
  output logic [31:0]                 bus_adr_o,
  input  logic                        bus_stb_ack_i,
  input  logic                        bus_ack_i,
  input  logic                        bus_err_i,
  input  logic [31:0]                 bus_adr_i,
  input  logic [icache_pkg::XLEN-1:0] bus_q_i
);
  import icache_pkg::*;

  // --------------------
  // internal links
  // --------------------
  fill_cmd_t  fill_cmd;   // miss start
  fill_word_t fill_word;  // one beat
  line_t      line;
  logic       line_full;
  logic       fill_done;
  logic       fill_err;

  icache_lookup #(
    .WAYS (WAYS)
  ) u_lookup (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .adr_i       (adr_i),
    .flush_i     (flush_i),
    .fill_cmd_o  (fill_cmd),
    .fill_done_i (fill_done),
    .fill_err_i  (fill_err),
    .line_i      (line),
    .line_full_i (line_full),
    .ack_o       (ack_o),
    .err_o       (err_o),
    .q_o         (q_o)
  );

  icache_fill_ctrl u_fill_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fill_cmd_i    (fill_cmd),
    .bus_stb_o     (bus_stb_o),
    .bus_adr_o     (bus_adr_o),
    .bus_stb_ack_i (bus_stb_ack_i),
    .bus_ack_i     (bus_ack_i),
    .bus_err_i     (bus_err_i),
    .bus_adr_i     (bus_adr_i),
    .bus_q_i       (bus_q_i),
    .fill_word_o   (fill_word),
    .fill_done_o   (fill_done),
    .fill_err_o    (fill_err)
  );

  icache_line_buf u_line_buf (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .fill_cmd_i  (fill_cmd),
    .fill_word_i (fill_word),
    .line_o      (line),
    .line_full_o (line_full)
  );

endmodule

// File: test/icache_checker.sv
`timescale 1ns/1ps

module icache_checker #(
  parameter logic [31:0] PATTERN   = 32'h0,
  parameter int          REQ_LIMIT = 48
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_i,      // DUT ports, watched only
  input  logic [31:0] adr_i,
  input  logic        ack_i,
  input  logic        err_i,
  input  logic [31:0] q_i,
  input  logic        bus_stb_i,
  input  logic [31:0] bus_adr_i,
  input  int          test_id_i,  // from the stimulus loop
  input  logic [1:0]  kind_i,
  output logic        done_o,     // one cycle per finished test
  output int          tests_o,
  output int          fails_o,
  output int          errors_o    // problems outside any test
);

  localparam logic [1:0] KIND_HIT  = 2'd0;
  localparam logic [1:0] KIND_MISS = 2'd1;
  localparam logic [1:0] KIND_ERR  = 2'd2;
  localparam logic [1:0] KIND_ANY  = 2'd3;

  int          cycle;
  logic        active;    // request out, no answer yet
  int          t_id;
  logic [1:0]  t_kind;
  logic [31:0] t_adr;
  int          t_cyc;     // cycle of the req_i edge
  logic        bus_seen;  // a burst was started for this test
  logic        bad;
  logic        stb_q;

  // memory word rule of the bus model
  function automatic logic [31:0] expect_word(input logic [31:0] a);
    return {a[31:2], 2'b00} ^ PATTERN;
  endfunction

  task close_test(input string outcome, input int lat);
    tests_o = tests_o + 1;
    if (bad)
      fails_o = fails_o + 1;
    $display("test %0d adr %08h: %s after %0d cycles, %s", t_id, t_adr, outcome, lat,
             bad ? "failed" : "ok");
    active = 1'b0;
    done_o <= 1'b1;
  endtask

  // --------------------
  // bus strobe rising
  // --------------------
  task check_strobe;
    if (!active)
    begin
      $display("bus strobe raised with no request pending");
      errors_o = errors_o + 1;
    end
    else
    begin
      bus_seen = 1'b1;
      if (t_kind == KIND_HIT)
      begin
        $display("test %0d: bus strobe on an access that should hit", t_id);
        bad = 1'b1;
      end
      if (bus_adr_i !== {t_adr[31:2], 2'b00})  // line base plus critical word
      begin
        $display("Fail test %0d: bus_adr_o = %08h, expected %08h", t_id, bus_adr_i,
                 {t_adr[31:2], 2'b00});
        bad = 1'b1;
      end
    end
  endtask

  // --------------------
  // answer of the cache
  // --------------------
  task watch_test;
    int lat;
    lat = cycle - t_cyc;
    if (ack_i)
    begin
      if (t_kind == KIND_ERR)
      begin
        $display("test %0d: ack_o came where a bus error was expected", t_id);
        bad = 1'b1;
      end
      else if (q_i !== expect_word(t_adr))
      begin
        $display("Fail test %0d: q_o = %08h, expected %08h", t_id, q_i, expect_word(t_adr));
        bad = 1'b1;
      end
      if ((t_kind == KIND_HIT || (t_kind == KIND_ANY && !bus_seen)) && lat != 1)
      begin
        $display("test %0d: hit answered after %0d cycles instead of 1", t_id, lat);
        bad = 1'b1;
      end
      if (t_kind == KIND_MISS && !bus_seen)
      begin
        $display("test %0d: expected a miss but the bus was never strobed", t_id);
        bad = 1'b1;
      end
      close_test(bus_seen ? "miss" : "hit", lat);
    end
    else if (err_i)
    begin
      if (t_kind != KIND_ERR)
      begin
        $display("test %0d: err_o raised without a bus error", t_id);
        bad = 1'b1;
      end
      close_test("error", lat);
    end
    else if (lat > REQ_LIMIT)
    begin
      $display("test %0d: no ack_o or err_o within %0d cycles", t_id, REQ_LIMIT);
      bad = 1'b1;
      close_test("no answer", lat);
    end
  endtask

  always @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      cycle    = 0;
      active   = 1'b0;
      stb_q    = 1'b0;
      tests_o  = 0;
      fails_o  = 0;
      errors_o = 0;
      done_o   <= 1'b0;
    end
    else
    begin
      cycle  = cycle + 1;
      done_o <= 1'b0;
      if (bus_stb_i && !stb_q)
        check_strobe();
      stb_q = bus_stb_i;
      if (req_i)
      begin
        active   = 1'b1;
        t_id     = test_id_i;
        t_kind   = kind_i;
        t_adr    = adr_i;
        t_cyc    = cycle;
        bus_seen = 1'b0;
        bad      = 1'b0;
      end
      else if (active)
        watch_test();
      else if (ack_i || err_i)
      begin
        $display("ack_o or err_o raised with no request pending");
        errors_o = errors_o + 1;
      end
    end
  end

endmodule

// File: test/tb_icache.sv
`timescale 1ns/1ps

module tb_icache;

  localparam int          WAYS         = 2;
  localparam logic [31:0] PATTERN      = 32'h5a3c_96e1;  // memory word key
  localparam logic [31:0] SEED         = 32'h2fd9_fe4a;
  localparam int          N_TESTS      = 24;
  localparam int          FILL_MAX_CYC = 48;  // 15 wait plus 4 beats of up to 4 plus lookup
  localparam int          TIMEOUT_CYC  = N_TESTS * (FILL_MAX_CYC + 4) + 100;

  localparam logic [1:0] KIND_HIT  = 2'd0;
  localparam logic [1:0] KIND_MISS = 2'd1;
  localparam logic [1:0] KIND_ERR  = 2'd2;
  localparam logic [1:0] KIND_ANY  = 2'd3;  // hit or miss with the data still checked

  typedef struct packed
  {
    logic [31:0] adr;
    logic        flush;     // flush_i raised with the request
    logic        err;
    logic [1:0]  err_beat;  // beat replaced by bus_err_i
    logic [1:0]  kind;
  } entry_t;

  logic        clk;
  logic        rst_n;
  logic        req;
  logic        flush;
  logic [31:0] req_adr;
  logic        ack;
  logic        err;
  logic [31:0] q;
  logic        bus_stb;
  logic [31:0] bus_adr_out;
  logic        bus_stb_ack;
  logic        bus_ack;
  logic        bus_err;
  logic [31:0] bus_adr;
  logic [31:0] bus_q;
  int          test_id;
  logic [1:0]  kind;
  logic        chk_done;
  int          n_tests;
  int          n_fail;
  int          n_err;
  logic [31:0] lfsr_q;
  logic        cur_err;
  logic [1:0]  cur_beat;
  int          cyc_cnt;
  entry_t      stim [N_TESTS];

  icache_top #(
    .WAYS (WAYS)
  ) dut0 (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .req_i         (req),
    .adr_i         (req_adr),
    .flush_i       (flush),
    .ack_o         (ack),
    .err_o         (err),
    .q_o           (q),
    .bus_stb_o     (bus_stb),
    .bus_adr_o     (bus_adr_out),
    .bus_stb_ack_i (bus_stb_ack),
    .bus_ack_i     (bus_ack),
    .bus_err_i     (bus_err),
    .bus_adr_i     (bus_adr),
    .bus_q_i       (bus_q)
  );

  icache_checker #(
    .PATTERN   (PATTERN),
    .REQ_LIMIT (FILL_MAX_CYC)
  ) check0 (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .req_i     (req),
    .adr_i     (req_adr),
    .ack_i     (ack),
    .err_i     (err),
    .q_i       (q),
    .bus_stb_i (bus_stb),
    .bus_adr_i (bus_adr_out),
    .test_id_i (test_id),
    .kind_i    (kind),
    .done_o    (chk_done),
    .tests_o   (n_tests),
    .fails_o   (n_fail),
    .errors_o  (n_err)
  );

  always #10 clk = ~clk;

  // --------------------
  // random source
  // --------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
  endfunction

  task automatic take_bits(input int n, output int v);
    v = 0;
    for (int b = 0; b < n; b++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = (v << 1) | int'(lfsr_q[0]);
    end
  endtask

  // --------------------
  // bus memory model
  // --------------------
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return {a[31:2], 2'b00} ^ PATTERN;
  endfunction

  task automatic serve_burst;
    int          dly;
    int          gap;
    logic [31:0] base;
    logic [1:0]  w;
    logic        stopped;
    take_bits(4, dly);           // strobe acknowledge wait
    repeat (dly) @(negedge clk);
    base        = bus_adr_out;
    bus_stb_ack = 1'b1;
    @(negedge clk);
    bus_stb_ack = 1'b0;
    stopped     = 1'b0;
    for (int k = 0; k < 4 && !stopped; k++)
    begin
      take_bits(2, gap);
      repeat (gap) @(negedge clk);
      w = base[3:2] + 2'(k);     // wrap from the critical word
      if (cur_err && cur_beat == 2'(k))
      begin
        bus_err = 1'b1;
        @(negedge clk);
        bus_err = 1'b0;
        stopped = 1'b1;
      end
      else
      begin
        bus_ack = 1'b1;
        bus_adr = {base[31:4], w, 2'b00};
        bus_q   = mem_word({base[31:4], w, 2'b00});
        @(negedge clk);
        bus_ack = 1'b0;
      end
    end
  endtask

  initial
  begin
    forever
    begin
      @(negedge clk);
      if (rst_n && bus_stb)
        serve_burst();
    end
  end

  // --------------------
  // stimulus
  // --------------------
  task automatic load_stim;
    stim[0]  = '{32'h0000_1004, 1'b0, 1'b0, 2'd0, KIND_MISS};  // cold miss on word 1
    stim[1]  = '{32'h0000_1008, 1'b0, 1'b0, 2'd0, KIND_HIT};
    stim[2]  = '{32'h0000_100c, 1'b0, 1'b0, 2'd0, KIND_HIT};
    stim[3]  = '{32'h0000_1000, 1'b0, 1'b0, 2'd0, KIND_HIT};
    stim[4]  = '{32'h0000_2238, 1'b0, 1'b0, 2'd0, KIND_MISS};
    stim[5]  = '{32'h0000_223c, 1'b0, 1'b0, 2'd0, KIND_HIT};
    stim[6]  = '{32'h0000_1004, 1'b0, 1'b0, 2'd0, KIND_HIT};
    stim[7]  = '{32'h0000_1004, 1'b1, 1'b0, 2'd0, KIND_MISS};  // served after the flush
    stim[8]  = '{32'h0000_2230, 1'b0, 1'b0, 2'd0, KIND_MISS};
    stim[9]  = '{32'h0000_1008, 1'b0, 1'b0, 2'd0, KIND_HIT};
    stim[10] = '{32'h0000_3450, 1'b0, 1'b1, 2'd2, KIND_ERR};   // dies after two beats
    stim[11] = '{32'h0000_3450, 1'b0, 1'b0, 2'd0, KIND_MISS};
    stim[12] = '{32'h0000_3454, 1'b0, 1'b0, 2'd0, KIND_HIT};
    stim[13] = '{32'h0000_4560, 1'b0, 1'b1, 2'd0, KIND_ERR};
    stim[14] = '{32'h0000_4564, 1'b0, 1'b0, 2'd0, KIND_MISS};
    stim[15] = '{32'h0001_0670, 1'b0, 1'b0, 2'd0, KIND_MISS};  // three tags in set 0x27
    stim[16] = '{32'h0002_067c, 1'b0, 1'b0, 2'd0, KIND_MISS};
    stim[17] = '{32'h0003_0674, 1'b0, 1'b0, 2'd0, KIND_MISS};
    stim[18] = '{32'h0001_0678, 1'b0, 1'b0, 2'd0, KIND_ANY};
    stim[19] = '{32'h0002_0670, 1'b0, 1'b0, 2'd0, KIND_ANY};
    stim[20] = '{32'h0003_0678, 1'b0, 1'b0, 2'd0, KIND_ANY};
    stim[21] = '{32'h0003_067c, 1'b0, 1'b0, 2'd0, KIND_ANY};
    stim[22] = '{32'hfffe_fff8, 1'b0, 1'b0, 2'd0, KIND_MISS};
    stim[23] = '{32'hfffe_fff0, 1'b0, 1'b0, 2'd0, KIND_HIT};
  endtask

  task automatic run_entry(input int i);
    test_id  = i;
    kind     = stim[i].kind;
    cur_err  = stim[i].err;
    cur_beat = stim[i].err_beat;
    req_adr  = stim[i].adr;
    flush    = stim[i].flush;
    req      = 1'b1;
    @(negedge clk);
    req   = 1'b0;
    flush = 1'b0;
    while (!chk_done)
      @(negedge clk);
    repeat (2) @(negedge clk);   // idle gap between tests
  endtask

  initial
  begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    req         = 1'b0;
    flush       = 1'b0;
    req_adr     = '0;
    bus_stb_ack = 1'b0;
    bus_ack     = 1'b0;
    bus_err     = 1'b0;
    bus_adr     = '0;
    bus_q       = '0;
    test_id     = 0;
    kind        = KIND_HIT;
    cur_err     = 1'b0;
    cur_beat    = 2'd0;
    lfsr_q      = SEED;
    load_stim();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);
    for (int i = 0; i < N_TESTS; i++)
      run_entry(i);
    repeat (4) @(negedge clk);
    $display("tests %0d of %0d, failed %0d, other errors %0d", n_tests, N_TESTS, n_fail,
             n_err);
    if (n_tests == N_TESTS && n_fail == 0 && n_err == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  // watchdog over the whole run
  initial
  begin
    cyc_cnt = 0;
    while (cyc_cnt < TIMEOUT_CYC)
    begin
      @(posedge clk);
      cyc_cnt = cyc_cnt + 1;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: list.f
logic/icache_pkg.sv
logic/icache_lookup.sv
logic/icache_line_buf.sv
logic/icache_fill_ctrl.sv
logic/icache_top.sv
test/icache_checker.sv
test/tb_icache.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall
TOP       := tb_icache
RTL_TOP   := icache_top
FILELIST  := list.f
OBJ_DIR   := obj_dir
PASS_MSG  := RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
